//--- sim.f
+incdir+include
hdl/or1420CiPkg.sv
hdl/resetSequencer.sv
hdl/pixelFormatIse.sv
hdl/profileControl.sv
hdl/profileCounter.sv
hdl/profileReadout.sv
hdl/or1420CiSubsystem.sv
test/or1420CiSubsystem_asserts.sv
test/or1420CiSubsystemTb.sv

//--- test/or1420CiSubsystemTb.sv
`timescale 1ns/1ps
`include "or1420Ci_cfg.svh"

module or1420CiSubsystemTb;

  localparam int SWAP_COUNT     = 100;
  localparam int GRAY_COUNT     = 100;
  localparam int PROFILE_CYCLES = 200;
  // reset phases, random ops with idle gaps, profiling, reads and unused ids
  localparam int TEST_CYCLES    = 8 + 2 * 24 + SWAP_COUNT + SWAP_COUNT / 10 + GRAY_COUNT
                                  + GRAY_COUNT / 10 + PROFILE_CYCLES + 16 + 8;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                    s_systemClock;
  logic                    s_pllLocked;
  logic                    ciStart;
  or1420CiPkg::ciId_t      ciN;
  or1420CiPkg::ciOperand_t ciDataA;
  or1420CiPkg::ciWord_t    ciDataB;
  logic                    stall;
  logic                    busIdle;
  logic                    ciDone;
  or1420CiPkg::ciWord_t    ciResult;
  logic                    resetReleased;

  int cycleCount = 0;

  // profiler reference state
  logic [31:0] modelCount [`PROFILE_COUNTERS];
  logic        modelFlag [`PROFILE_COUNTERS];
  logic        stallSeen;
  logic        busIdleSeen;

  or1420CiSubsystem or1420CiSubsystem_i (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .stall        (stall),
    .busIdle      (busIdle),
    .ciDone       (ciDone),
    .ciResult     (ciResult),
    .resetReleased(resetReleased)
  );

  bind or1420CiSubsystem or1420CiSubsystem_asserts asserts_i (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ciStart      (ciStart),
    .ciDone       (ciDone),
    .ciResult     (ciResult),
    .resetReleased(resetReleased)
  );

  always #5 s_systemClock = ~s_systemClock;

  always @(posedge s_systemClock) begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      abortRun($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  always @(negedge s_systemClock) begin
    if (or1420CiSubsystem_i.asserts_i.failureCount != 0) begin
      abortRun("A bound protocol assertion failed");
    end
  end

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic reportMismatch(input string signalName, input logic [31:0] expected,
                                input logic [31:0] actual);
    abortRun($sformatf("Error: %s expected 0x%08h, got 0x%08h", signalName, expected, actual));
  endtask

  function automatic logic [31:0] reversedBytes(input logic [31:0] a);
    return {a[7:0], a[15:8], a[23:16], a[31:24]};
  endfunction

  // rgb565 widened to 8 bits per channel, weighted, divided by 256
  function automatic logic [31:0] expectedGray(input logic [31:0] a);
    int red;
    int green;
    int blue;
    red   = a[15:11] * 8;
    green = a[10:5] * 4;
    blue  = a[4:0] * 8;
    return 32'((red * 54 + green * 183 + blue * 19) / 256);
  endfunction

  task automatic resetProfileModel();
    for (int i = 0; i < `PROFILE_COUNTERS; i++) begin
      modelCount[i] = '0;
      modelFlag[i]  = 1'b0;
    end
    stallSeen   = 1'b0;
    busIdleSeen = 1'b0;
  endtask

  // state after the rising edge that closes the current cycle
  task automatic advanceProfileModel(input logic start, input logic [7:0] n,
                                     input logic [31:0] b, input logic st, input logic bi);
    logic eventHigh [`PROFILE_COUNTERS];
    logic hit;
    hit          = start && (n == `CI_PROFILE_ID);
    eventHigh[0] = 1'b1;
    eventHigh[1] = stallSeen;  // inputs from the cycle before
    eventHigh[2] = busIdleSeen;
    eventHigh[3] = !stallSeen;
    for (int i = 0; i < `PROFILE_COUNTERS; i++) begin
      if (hit && b[8 + i]) begin
        modelCount[i] = '0;
      end else if (modelFlag[i] && eventHigh[i]) begin
        modelCount[i] = modelCount[i] + 1;
      end
      if (hit && b[i]) begin
        modelFlag[i] = 1'b1;
      end else if (hit && b[4 + i]) begin
        modelFlag[i] = 1'b0;
      end
    end
    stallSeen   = st;
    busIdleSeen = bi;
  endtask

  task automatic compareResponse(input logic start, input logic [7:0] n, input logic [31:0] a);
    logic        expDone;
    logic [31:0] expResult;
    expDone   = 1'b0;
    expResult = '0;
    if (start) begin
      case (n)
        `CI_SWAP_BYTE_ID: begin
          expDone   = 1'b1;
          expResult = reversedBytes(a);
        end
        `CI_RGB2GRAY_ID: begin
          expDone   = 1'b1;
          expResult = expectedGray(a);
        end
        `CI_PROFILE_ID: begin
          expDone   = 1'b1;
          expResult = modelCount[a[1:0]];  // value before this instruction acts
        end
        default: begin
          expDone = 1'b0;
        end
      endcase
    end
    assert (ciDone === expDone) else reportMismatch("ciDone", 32'(expDone), 32'(ciDone));
    assert (ciResult === expResult) else reportMismatch("ciResult", expResult, ciResult);
  endtask

  // one bus cycle checked at the falling edge
  task automatic driveCycle(input logic start, input logic [7:0] n, input logic [31:0] a,
                            input logic [31:0] b, input logic st, input logic bi);
    @(posedge s_systemClock);
    #1;
    ciStart = start;
    ciN     = n;
    ciDataA = a;
    ciDataB = b;
    stall   = st;
    busIdle = bi;
    @(negedge s_systemClock);
    compareResponse(start, n, a);
    advanceProfileModel(start, n, b, st, bi);
  endtask

  task automatic watchResetRelease();
    logic expected;
    @(posedge s_systemClock);
    #1;
    s_pllLocked = 1'b1;
    for (int edgeNo = 1; edgeNo <= 20; edgeNo++) begin
      @(posedge s_systemClock);
      @(negedge s_systemClock);
      expected = (edgeNo >= 16);
      assert (resetReleased === expected)
      else reportMismatch("resetReleased", 32'(expected), 32'(resetReleased));
    end
  endtask

  initial begin
    logic [31:0] operand;
    s_systemClock = 1'b0;
    s_pllLocked   = 1'b0;
    ciStart       = 1'b0;
    ciN           = '0;
    ciDataA       = '0;
    ciDataB       = '0;
    stall         = 1'b0;
    busIdle       = 1'b0;
    void'($urandom(32'h2032782d));

    repeat (8) begin
      @(negedge s_systemClock);
      assert (resetReleased === 1'b0)
      else reportMismatch("resetReleased", 32'h0, 32'(resetReleased));
    end
    watchResetRelease();

    // lock loss clears the release at once
    @(posedge s_systemClock);
    #1;
    s_pllLocked = 1'b0;
    #1;
    assert (resetReleased === 1'b0)
    else reportMismatch("resetReleased", 32'h0, 32'(resetReleased));
    repeat (2) @(posedge s_systemClock);
    watchResetRelease();
    resetProfileModel();

    for (int i = 0; i < SWAP_COUNT; i++) begin
      driveCycle(1'b1, `CI_SWAP_BYTE_ID, $urandom, $urandom, 1'b0, 1'b0);
      if (i % 10 == 9) begin
        driveCycle(1'b0, `CI_SWAP_BYTE_ID, $urandom, $urandom, 1'b0, 1'b0);  // no start
      end
    end

    for (int i = 0; i < GRAY_COUNT; i++) begin
      if (i == 0) begin
        operand = 32'h0000_0000;
      end else if (i == 1) begin
        operand = 32'hffff_ffff;
      end else begin
        operand = $urandom;
      end
      driveCycle(1'b1, `CI_RGB2GRAY_ID, operand, $urandom, 1'b0, 1'b0);
      if (i % 10 == 9) begin
        driveCycle(1'b0, `CI_RGB2GRAY_ID, $urandom, $urandom, 1'b0, 1'b0);
      end
    end

    // clear and enable together, then random events
    driveCycle(1'b1, `CI_PROFILE_ID, 32'h0, 32'h0000_0f0f, $urandom_range(0, 1),
               $urandom_range(0, 1));
    for (int i = 0; i < PROFILE_CYCLES; i++) begin
      driveCycle(1'b0, 8'($urandom), $urandom, $urandom, $urandom_range(0, 1),
                 $urandom_range(0, 1));
    end
    driveCycle(1'b1, `CI_PROFILE_ID, 32'h0, 32'h0000_00f0, $urandom_range(0, 1),
               $urandom_range(0, 1));
    for (int sel = 0; sel < `PROFILE_COUNTERS; sel++) begin
      operand = ($urandom & 32'hffff_fffc) | 32'(sel);  // only bits 1..0 select
      driveCycle(1'b1, `CI_PROFILE_ID, operand, 32'h0, $urandom_range(0, 1),
                 $urandom_range(0, 1));
    end

    driveCycle(1'b1, `CI_PROFILE_ID, 32'h0, 32'h0000_0f00, 1'b0, 1'b0);
    for (int sel = 0; sel < `PROFILE_COUNTERS; sel++) begin
      driveCycle(1'b1, `CI_PROFILE_ID, 32'(sel), 32'h0, 1'b1, 1'b1);
      assert (ciResult === 32'h0) else reportMismatch("ciResult", 32'h0, ciResult);
    end

    // unused numbers
    driveCycle(1'b1, 8'd0, $urandom, $urandom, 1'b0, 1'b0);
    driveCycle(1'b1, 8'd4, $urandom, $urandom, 1'b0, 1'b0);
    driveCycle(1'b1, 8'd255, $urandom, $urandom, 1'b0, 1'b0);
    driveCycle(1'b0, 8'd0, 32'h0, 32'h0, 1'b0, 1'b0);

    @(posedge s_systemClock);
    @(negedge s_systemClock);
    if (or1420CiSubsystem_i.asserts_i.failureCount == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      abortRun("A bound protocol assertion failed");
    end
  end

endmodule

//--- test/or1420CiSubsystem_asserts.sv
`timescale 1ns/1ps

module or1420CiSubsystem_asserts (
  input logic                 s_systemClock,
  input logic                 s_pllLocked,
  input logic                 ciStart,
  input logic                 ciDone,
  input or1420CiPkg::ciWord_t ciResult,
  input logic                 resetReleased
);

  // count of failed properties
  int failureCount = 0;

  // combinational answer, so done only ever comes with a start
  property doneNeedsStart;
    @(posedge s_systemClock) ciDone |-> ciStart;
  endproperty

  // wired-OR result bus stays quiet when no unit answers
  property quietResultWhenIdle;
    @(posedge s_systemClock) !ciDone |-> (ciResult == '0);
  endproperty

  property releaseHeldWhileLocked;
    @(posedge s_systemClock) $fell(resetReleased) |-> !s_pllLocked;
  endproperty

  doneNeedsStartCheck : assert property (doneNeedsStart)
  else begin
    failureCount++;
    $error("ciDone high without ciStart");
  end

  quietResultCheck : assert property (quietResultWhenIdle)
  else begin
    failureCount++;
    $error("ciResult nonzero while ciDone low");
  end

  releaseHeldCheck : assert property (releaseHeldWhileLocked)
  else begin
    failureCount++;
    $error("resetReleased fell while the PLL stayed locked");
  end

endmodule

//--- hdl/or1420CiSubsystem.sv
`timescale 1ns/1ps
`include "or1420Ci_cfg.svh"

module or1420CiSubsystem (
  input  logic                    s_systemClock,
  input  logic                    s_pllLocked,
  input  logic                    ciStart,
  input  or1420CiPkg::ciId_t      ciN,
  input  or1420CiPkg::ciOperand_t ciDataA,
  input  or1420CiPkg::ciWord_t    ciDataB,
  input  logic                    stall,
  input  logic                    busIdle,
  output logic                    ciDone,
  output or1420CiPkg::ciWord_t    ciResult,
  output logic                    resetReleased
);

  logic                         s_coreReset;
  logic                         s_pixelDone;
  or1420CiPkg::ciWord_t         s_pixelResult;
  logic                         s_profileStart;
  logic                         s_profileDone;
  or1420CiPkg::ciWord_t         s_profileResult;
  logic [`PROFILE_COUNTERS-1:0] s_enablePulse;
  logic [`PROFILE_COUNTERS-1:0] s_disablePulse;
  logic [`PROFILE_COUNTERS-1:0] s_clearPulse;
  logic [`PROFILE_COUNTERS-1:0] s_countEvent;
  or1420CiPkg::profileCount_t   s_counts [`PROFILE_COUNTERS];

  resetSequencer resetSequencer_i (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .coreReset    (s_coreReset),
    .resetReleased(resetReleased)
  );

  // byte swap and gray
  pixelFormatIse pixelFormatIse_i (
    .ciStart (ciStart),
    .ciN     (ciN),
    .ciDataA (ciDataA),
    .ciDone  (s_pixelDone),
    .ciResult(s_pixelResult)
  );

  profileControl profileControl_i (
    .s_systemClock(s_systemClock),
    .coreReset    (s_coreReset),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataB      (ciDataB),
    .stall        (stall),
    .busIdle      (busIdle),
    .profileStart (s_profileStart),
    .enablePulse  (s_enablePulse),
    .disablePulse (s_disablePulse),
    .clearPulse   (s_clearPulse),
    .countEvent   (s_countEvent)
  );

  for (genvar i = 0; i < `PROFILE_COUNTERS; i++) begin : counterGen
    profileCounter profileCounter_i (
      .s_systemClock(s_systemClock),
      .coreReset    (s_coreReset),
      .enablePulse  (s_enablePulse[i]),
      .disablePulse (s_disablePulse[i]),
      .clearPulse   (s_clearPulse[i]),
      .countEvent   (s_countEvent[i]),
      .count        (s_counts[i])
    );
  end

  profileReadout profileReadout_i (
    .profileStart (s_profileStart),
    .counterSelect(ciDataA.bytes[0][1:0]),
    .counts       (s_counts),
    .ciDone       (s_profileDone),
    .ciResult     (s_profileResult)
  );

  // wired-OR of all units
  assign ciDone   = s_pixelDone | s_profileDone;
  assign ciResult = s_pixelResult | s_profileResult;

endmodule

//--- hdl/profileReadout.sv
`timescale 1ns/1ps
`include "or1420Ci_cfg.svh"

module profileReadout (
  input  logic                       profileStart,
  input  logic [1:0]                 counterSelect,
  input  or1420CiPkg::profileCount_t counts [`PROFILE_COUNTERS],
  output logic                       ciDone,
  output or1420CiPkg::ciWord_t       ciResult
);

  or1420CiPkg::profileCount_t selected;

  // counts are registers, so this is the value before the instruction acts
  assign selected = counts[counterSelect];

  assign ciDone = profileStart;

  always_comb begin
    if (profileStart) begin
      ciResult = selected;
    end else begin
      ciResult = '0;  // quiet on the shared result
    end
  end

endmodule

//--- hdl/profileCounter.sv
`timescale 1ns/1ps

module profileCounter (
  input  logic                       s_systemClock,
  input  logic                       coreReset,
  input  logic                       enablePulse,
  input  logic                       disablePulse,
  input  logic                       clearPulse,
  input  logic                       countEvent,
  output or1420CiPkg::profileCount_t count
);

  logic enableFlag;

  always_ff @(posedge s_systemClock or posedge coreReset) begin
    if (coreReset) begin
      enableFlag <= 1'b0;
      count      <= '0;
    end else begin
      if (enablePulse) begin
        enableFlag <= 1'b1;  // enable wins
      end else if (disablePulse) begin
        enableFlag <= 1'b0;
      end
      if (clearPulse) begin
        count <= '0;
      end else if (enableFlag && countEvent) begin
        count <= count + 1'b1;  // wraps at 2^32
      end
    end
  end

endmodule

//--- hdl/profileControl.sv
`timescale 1ns/1ps
`include "or1420Ci_cfg.svh"

module profileControl (
  input  logic                         s_systemClock,
  input  logic                         coreReset,
  input  logic                         ciStart,
  input  or1420CiPkg::ciId_t           ciN,
  input  or1420CiPkg::ciWord_t         ciDataB,
  input  logic                         stall,
  input  logic                         busIdle,
  output logic                         profileStart,
  output logic [`PROFILE_COUNTERS-1:0] enablePulse,
  output logic [`PROFILE_COUNTERS-1:0] disablePulse,
  output logic [`PROFILE_COUNTERS-1:0] clearPulse,
  output logic [`PROFILE_COUNTERS-1:0] countEvent
);

  logic stallReg;
  logic busIdleReg;

  assign profileStart = ciStart && (ciN == `CI_PROFILE_ID);

  // enable, disable and clear fields of operand B
  assign enablePulse  = profileStart ? ciDataB[`PROFILE_COUNTERS-1:0] : '0;
  assign disablePulse = profileStart ?
                        ciDataB[2*`PROFILE_COUNTERS-1:`PROFILE_COUNTERS] : '0;
  assign clearPulse   = profileStart ?
                        ciDataB[3*`PROFILE_COUNTERS-1:2*`PROFILE_COUNTERS] : '0;

  // events land one cycle late
  always_ff @(posedge s_systemClock or posedge coreReset) begin
    if (coreReset) begin
      stallReg   <= 1'b0;
      busIdleReg <= 1'b0;
    end else begin
      stallReg   <= stall;
      busIdleReg <= busIdle;
    end
  end

  // cycles, stalls, bus idle, running
  assign countEvent = {~stallReg, busIdleReg, stallReg, 1'b1};

endmodule

//--- hdl/pixelFormatIse.sv
`timescale 1ns/1ps
`include "or1420Ci_cfg.svh"

module pixelFormatIse (
  input  logic                    ciStart,
  input  or1420CiPkg::ciId_t      ciN,
  input  or1420CiPkg::ciOperand_t ciDataA,
  output logic                    ciDone,
  output or1420CiPkg::ciWord_t    ciResult
);

  logic                 swapHit;
  logic                 grayHit;
  or1420CiPkg::ciWord_t swapped;
  or1420CiPkg::rgb565_t pixel;
  logic [7:0]           red8;
  logic [7:0]           green8;
  logic [7:0]           blue8;
  logic [15:0]          graySum;

  assign swapHit = ciStart && (ciN == `CI_SWAP_BYTE_ID);
  assign grayHit = ciStart && (ciN == `CI_RGB2GRAY_ID);
  assign ciDone  = swapHit | grayHit;

  // byte k of the result is operand byte 3-k
  assign swapped = {ciDataA.bytes[0], ciDataA.bytes[1],
                    ciDataA.bytes[2], ciDataA.bytes[3]};

  assign pixel  = ciDataA.pixelView.pixel;
  assign red8   = {pixel.red, 3'b000};
  assign green8 = {pixel.green, 2'b00};
  assign blue8  = {pixel.blue, 3'b000};

  // max sum stays below 2^16
  assign graySum = 16'(red8) * 16'(`GRAY_RED_WEIGHT) +
                   16'(green8) * 16'(`GRAY_GREEN_WEIGHT) +
                   16'(blue8) * 16'(`GRAY_BLUE_WEIGHT);

  // idle unit drives zero for the wired-OR
  always_comb begin
    if (swapHit) begin
      ciResult = swapped;
    end else if (grayHit) begin
      ciResult = {24'd0, graySum[15:8]};
    end else begin
      ciResult = '0;
    end
  end

endmodule

//--- hdl/resetSequencer.sv
`timescale 1ns/1ps
`include "or1420Ci_cfg.svh"

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic coreReset,
  output logic resetReleased
);

  logic [`RESET_COUNT_BITS-1:0] resetCount;

  // counts up after lock, then holds on the top bit
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[`RESET_COUNT_BITS-1]) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign resetReleased = resetCount[`RESET_COUNT_BITS-1];
  assign coreReset     = ~resetReleased;  // active high

endmodule

//--- hdl/or1420CiPkg.sv
package or1420CiPkg;

  // custom instruction number
  typedef logic [7:0] ciId_t;

  // operand or result word
  typedef logic [31:0] ciWord_t;

  typedef struct packed {
    logic [4:0] red;    // top bits
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  typedef struct packed {
    logic [15:0] upperHalf;
    rgb565_t     pixel;
  } pixelView_t;

  // operand A seen as four bytes or as a pixel in the low half
  typedef union packed {
    logic [3:0][7:0] bytes;     // byte 0 least significant
    pixelView_t      pixelView;
  } ciOperand_t;

  typedef logic [31:0] profileCount_t;

endpackage

//--- include/or1420Ci_cfg.svh
`ifndef OR1420CI_CFG_SVH
`define OR1420CI_CFG_SVH

// custom instruction numbers
`define CI_SWAP_BYTE_ID 8'd1
`define CI_PROFILE_ID 8'd12
`define CI_RGB2GRAY_ID 8'd13

// profiler
`define PROFILE_COUNTERS 4

// top bit of the reset counter marks release after 16 cycles
`define RESET_COUNT_BITS 5

// luma weights summing to 256
`define GRAY_RED_WEIGHT 8'd54
`define GRAY_GREEN_WEIGHT 8'd183
`define GRAY_BLUE_WEIGHT 8'd19

`endif
